/* src.f */
+incdir+common
common/ulpb_pkg.sv
mediator/ulpb_mediator.sv
hdl/ulpb_tx_node.sv
hdl/ulpb_rx_node.sv
hdl/ulpb_ring.sv
bench/ulpb_clk_gen.sv
bench/ulpb_checker.sv
bench/ulpb_tb.sv

/* run_sim.sh */
#!/bin/bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ulpb_tb -f src.f -o sim_ulpb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_ulpb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

/* bench/ulpb_tb.sv */
`timescale 1ns/1ps
`include "ulpb_config.svh"

module ulpb_tb;

	import ulpb_pkg::*;

	localparam int NUM_FRAMES = 40;
	localparam int FRAME_CYCLES = 120;	// One frame plus the idle hold
	localparam int MAX_CYCLES = NUM_FRAMES * FRAME_CYCLES;
	localparam int IDLE_CHECKS = 30;

	logic CLK_IN;
	logic RESET;
	logic req;
	addr_t tx_addr;
	data_t tx_data;
	logic tx_done;
	logic rx_valid;
	data_t rx_data;
	logic bus_clk;

	integer seed;
	int value_errs = 0;
	int other_errs = 0;
	int cycle_cnt = 0;
	int done_rises = 0;
	int ring_edges = 0;
	logic done_q = 1'b0;
	logic exp_valid;
	data_t exp_data;

	ulpb_clk_gen clk_gen
	(
		.CLK_IN (CLK_IN),
		.RESET  (RESET)
	);

	ulpb_ring UUT
	(
		.CLK_IN   (CLK_IN),
		.RESET    (RESET),
		.req      (req),
		.tx_addr  (tx_addr),
		.tx_data  (tx_data),
		.tx_done  (tx_done),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.bus_clk  (bus_clk)
	);

	// Counts tx_done rising edges
	always @(negedge CLK_IN)
	begin
		done_q <= tx_done;
		if (tx_done && !done_q)
			done_rises <= done_rises + 1;
	end

	// Counts ring clock rising edges
	always @(posedge bus_clk)
		ring_edges <= ring_edges + 1;

	always @(posedge CLK_IN)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES)
		begin
			other_errs++;
			$display("Timeout: the frames did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		begin
			if (exp !== act)
			begin
				$display("ERR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
				value_errs++;
			end
		end
	endtask

	// Sends one frame and checks the result against the address match rule
	task automatic run_frame(input addr_t addr, input data_t data);
		int rises_before;
		int edges_before;
		logic prev_done;
		logic saw_clear;
		logic done_seen;
		begin
			tx_addr = addr;
			tx_data = data;
			req = 1'b1;
			rises_before = done_rises;
			prev_done = tx_done;
			saw_clear = 1'b0;
			done_seen = 1'b0;
			while (!done_seen)
			begin
				@(negedge CLK_IN);
				if (!rx_valid)
					saw_clear = 1'b1;	// Old result dropped at arbitration
				if (tx_done && !prev_done)
					done_seen = 1'b1;
				prev_done = tx_done;
			end
			req = 1'b0;	// Must drop before bus_disable ends
			edges_before = ring_edges;

			exp_valid = (addr == addr_t'(`ULPB_RX_ADDR));
			if (exp_valid)
				exp_data = data;
			check_value("rx_valid", 32'(exp_valid), 32'(rx_valid));
			check_value("rx_data", 32'(exp_data), 32'(rx_data));
			check_value("rx_valid_cleared", 1, 32'(saw_clear));

			for (int k = 0; k < IDLE_CHECKS; k++)
			begin
				@(negedge CLK_IN);
				check_value("bus_clk", 1, 32'(bus_clk));
			end
			check_value("bus_clk_edges", 0, ring_edges - edges_before);
			check_value("tx_done_rises", 1, done_rises - rises_before);
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		addr_t addr;
		data_t data;
		int edges_start;

		seed = 32'h8275_169d;
		req = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		exp_data = '0;	// rx_data after reset
		exp_valid = 1'b0;

		while (RESET !== 1'b1)
			@(negedge CLK_IN);
		edges_start = ring_edges;
		@(negedge CLK_IN);
		check_value("bus_clk", 1, 32'(bus_clk));
		check_value("bus_clk_edges", 0, ring_edges - edges_start);
		check_value("tx_done", 0, 32'(tx_done));
		check_value("rx_valid", 0, 32'(rx_valid));

		for (int i = 0; i < NUM_FRAMES; i++)
		begin
			rnd = $random(seed);
			addr = rnd[`ULPB_ADDR_W-1:0];
			rnd = $random(seed);
			data = rnd[`ULPB_DATA_W-1:0];
			rnd = $random(seed);
			if (rnd[0])
				addr = `ULPB_RX_ADDR;	// Roughly half hit the receiver
			run_frame(addr, data);
		end

		$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* bench/ulpb_checker.sv */
`timescale 1ns/1ps
`include "ulpb_config.svh"

module ulpb_checker
(
	input logic                 CLK_IN,
	input logic                 RESET,
	input ulpb_pkg::med_state_t state,
	input logic                 CLK_OUT,
	input logic                 DOUT
);

	import ulpb_pkg::*;

	int unsigned wait_cnt;	// Cycles spent in wait_for_start

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
			wait_cnt <= 0;
		else if (state == wait_for_start)
			wait_cnt <= wait_cnt + 1;
		else
			wait_cnt <= 0;
	end

	idle_clk_high: assert property (@(posedge CLK_IN) disable iff (!RESET)
		(state == bus_idle) |-> CLK_OUT)
		else $error("Ring clock not parked high in bus_idle");

	hold_line_high: assert property (@(posedge CLK_IN) disable iff (!RESET)
		(state inside {bus_idle, bus_reset, bus_disable}) |-> DOUT)
		else $error("Mediator DOUT not held high while owning the line");

	start_delay: assert property (@(posedge CLK_IN) disable iff (!RESET)
		$fell(state == wait_for_start) |-> (wait_cnt == `ULPB_START_CYCLES))
		else $error("Mediator left wait_for_start after the wrong number of cycles");

endmodule

bind ulpb_mediator ulpb_checker u_checker
(
	.CLK_IN  (CLK_IN),
	.RESET   (RESET),
	.state   (state),
	.CLK_OUT (CLK_OUT),
	.DOUT    (DOUT)
);

/* bench/ulpb_clk_gen.sv */
`timescale 1ns/1ps

module ulpb_clk_gen
(
	output logic CLK_IN,
	output logic RESET
);

	localparam int HALF_PERIOD = 10;	// 20 ns period
	localparam int RESET_CYCLES = 16;

	initial
	begin
		CLK_IN = 1'b0;
		forever
			#HALF_PERIOD CLK_IN = ~CLK_IN;
	end

	initial
	begin
		RESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_IN);
		@(negedge CLK_IN);	// Release away from the active edge
		RESET = 1'b1;
	end

endmodule

/* hdl/ulpb_ring.sv */
`timescale 1ns/1ps

module ulpb_ring
(
	input  logic            CLK_IN,
	input  logic            RESET,
	input  logic            req,
	input  ulpb_pkg::addr_t tx_addr,
	input  ulpb_pkg::data_t tx_data,
	output logic            tx_done,
	output logic            rx_valid,
	output ulpb_pkg::data_t rx_data,
	output logic            bus_clk
);

	logic med_dout;
	logic tx_dout;
	logic rx_dout;

	ulpb_mediator u_mediator
	(
		.CLK_IN  (CLK_IN),
		.RESET   (RESET),
		.DIN     (rx_dout),	// Ring closes here
		.DOUT    (med_dout),
		.CLK_OUT (bus_clk)
	);

	ulpb_tx_node u_tx_node
	(
		.bus_clk (bus_clk),
		.RESET   (RESET),
		.DIN     (med_dout),
		.DOUT    (tx_dout),
		.req     (req),
		.tx_addr (tx_addr),
		.tx_data (tx_data),
		.tx_done (tx_done)
	);

	ulpb_rx_node u_rx_node
	(
		.bus_clk  (bus_clk),
		.RESET    (RESET),
		.DIN      (tx_dout),
		.DOUT     (rx_dout),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

endmodule

/* hdl/ulpb_rx_node.sv */
`timescale 1ns/1ps
`include "ulpb_config.svh"

module ulpb_rx_node
(
	input  logic            bus_clk,
	input  logic            RESET,
	input  logic            DIN,
	output logic            DOUT,
	output logic            rx_valid,
	output ulpb_pkg::data_t rx_data
);

	import ulpb_pkg::*;

	localparam int FRAME_W = `ULPB_ADDR_W + `ULPB_DATA_W;
	localparam int CNT_W = $clog2(FRAME_W + 2);
	// Edges from the end decision up to the last ring clock edge
	localparam int TRAIL_EDGES = 5 + `ULPB_RESET_CYCLES;
	localparam int TRAIL_W = $clog2(TRAIL_EDGES);

	node_state_t state;
	phase_t phase;
	logic first_q;
	logic [FRAME_W-1:0] frame_q;
	logic [CNT_W-1:0] bit_cnt;
	logic [TRAIL_W-1:0] trail_cnt;
	logic sample1, sample2, frame_end, frame_ok;

	assign DOUT = DIN;

	assign sample1 = (state == node_frame) && (phase == 2'd0);	// r+1
	assign sample2 = (state == node_frame) && (phase == 2'd2);	// r+3
	assign frame_end = sample2 && (first_q != DIN);
	assign frame_ok = (bit_cnt == CNT_W'(FRAME_W)) &&
		(frame_q[FRAME_W-1 -: `ULPB_ADDR_W] == addr_t'(`ULPB_RX_ADDR));

	always_ff @(posedge bus_clk or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= node_idle;
			phase <= 2'd3;
			bit_cnt <= '0;
			trail_cnt <= '0;
			rx_valid <= 1'b0;
			rx_data <= '0;
		end
		else
		begin
			case (state)
				node_idle:
				begin
					state <= node_frame;	// First ring edge is arbitration
					phase <= 2'd3;
					bit_cnt <= '0;
					rx_valid <= 1'b0;
				end
				node_frame:
				begin
					phase <= phase + 2'd1;
					if (frame_end)
					begin
						if (frame_ok)
						begin
							rx_valid <= 1'b1;
							rx_data <= frame_q[`ULPB_DATA_W-1:0];
						end
						state <= node_trailer;
						trail_cnt <= TRAIL_W'(TRAIL_EDGES - 1);
					end
					else if (sample2 && bit_cnt != CNT_W'(FRAME_W + 1))
						bit_cnt <= bit_cnt + 1'b1;	// Saturates on long frames
				end
				node_trailer:
				begin
					if (trail_cnt != '0)
						trail_cnt <= trail_cnt - 1'b1;
					else
						state <= node_idle;
				end
				default:
					state <= node_idle;
			endcase
		end
	end

	always_ff @(posedge bus_clk)
	begin
		if (sample1)
			first_q <= DIN;
		if (sample2 && first_q == DIN)
			frame_q <= {frame_q[FRAME_W-2:0], DIN};
	end

endmodule

/* hdl/ulpb_tx_node.sv */
`timescale 1ns/1ps
`include "ulpb_config.svh"

module ulpb_tx_node
(
	input  logic            bus_clk,
	input  logic            RESET,
	input  logic            DIN,
	output logic            DOUT,
	input  logic            req,
	input  ulpb_pkg::addr_t tx_addr,
	input  ulpb_pkg::data_t tx_data,
	output logic            tx_done
);

	import ulpb_pkg::*;

	localparam int FRAME_W = `ULPB_ADDR_W + `ULPB_DATA_W;
	localparam int CNT_W = $clog2(FRAME_W + 2);
	// Edges from the mid-round toggle up to the last ring clock edge
	localparam int TRAIL_EDGES = 6 + `ULPB_RESET_CYCLES;
	localparam int TRAIL_W = $clog2(TRAIL_EDGES);

	node_state_t state;
	phase_t phase;
	logic [FRAME_W-1:0] shreg;
	logic [CNT_W-1:0] bit_cnt;
	logic [TRAIL_W-1:0] trail_cnt;
	logic line_q;
	logic round_start, mid_round, start_edge;

	assign round_start = (phase == 2'd3);
	assign mid_round = (phase == 2'd1);
	assign start_edge = (state == node_idle) && req;

	always_comb
	begin
		if (state != node_idle)
			DOUT = line_q;	// Own level breaks the ring loop
		else if (req)
			DOUT = 1'b0;
		else
			DOUT = DIN;
	end

	always_ff @(posedge bus_clk or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= node_idle;
			phase <= 2'd3;
			bit_cnt <= '0;
			trail_cnt <= '0;
			line_q <= 1'b1;
			tx_done <= 1'b0;
		end
		else
		begin
			case (state)
				node_idle:
				begin
					if (req)	// Arbitration edge
					begin
						state <= node_frame;
						phase <= 2'd3;
						bit_cnt <= '0;
						line_q <= 1'b0;
						tx_done <= 1'b0;
					end
				end
				node_frame:
				begin
					phase <= phase + 2'd1;
					if (round_start)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt < CNT_W'(FRAME_W))
							line_q <= shreg[FRAME_W-1];
					end
					else if (mid_round && bit_cnt == CNT_W'(FRAME_W + 1))
					begin
						line_q <= ~line_q;	// End of frame mark
						state <= node_trailer;
						trail_cnt <= TRAIL_W'(TRAIL_EDGES - 1);
					end
				end
				node_trailer:
				begin
					if (trail_cnt != '0)
						trail_cnt <= trail_cnt - 1'b1;
					else
					begin
						state <= node_idle;
						tx_done <= 1'b1;
					end
				end
				default:
					state <= node_idle;
			endcase
		end
	end

	always_ff @(posedge bus_clk)
	begin
		if (start_edge)
			shreg <= {tx_addr, tx_data};	// MSB first
		else if (state == node_frame && round_start)
			shreg <= {shreg[FRAME_W-2:0], 1'b0};
	end

endmodule

/* mediator/ulpb_mediator.sv */
`timescale 1ns/1ps
`include "ulpb_config.svh"

module ulpb_mediator
(
	input  logic CLK_IN,
	input  logic RESET,
	input  logic DIN,
	output logic DOUT,
	output logic CLK_OUT
);

	import ulpb_pkg::*;

	localparam int CNT_MAX = (`ULPB_START_CYCLES > `ULPB_RESET_CYCLES) ?
		`ULPB_START_CYCLES : `ULPB_RESET_CYCLES;
	localparam int CNT_W = $clog2(CNT_MAX);

	med_state_t state, next_state;
	logic clk_en, next_clk_en;
	logic ctrl_hold, next_ctrl_hold;
	logic reset_armed, next_reset_armed;
	logic [1:0] in_buf, next_in_buf;
	logic [CNT_W-1:0] cycle_cnt, next_cycle_cnt;
	logic sample_diff;

	assign sample_diff = in_buf[1] ^ in_buf[0];	// Mid-round level change
	assign CLK_OUT = CLK_IN | ~clk_en;	// Parked high while disabled
	assign DOUT = ctrl_hold ? 1'b1 : DIN;

	always_ff @(posedge CLK_IN or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= bus_idle;
			clk_en <= 1'b0;
			ctrl_hold <= 1'b1;
			reset_armed <= 1'b0;
			in_buf <= 2'b00;
			cycle_cnt <= CNT_W'(`ULPB_START_CYCLES - 1);
		end
		else
		begin
			state <= next_state;
			clk_en <= next_clk_en;
			ctrl_hold <= next_ctrl_hold;
			reset_armed <= next_reset_armed;
			in_buf <= next_in_buf;
			cycle_cnt <= next_cycle_cnt;
		end
	end

	always_comb
	begin
		next_state = state;
		next_clk_en = clk_en;
		next_ctrl_hold = ctrl_hold;
		next_reset_armed = reset_armed;
		next_in_buf = in_buf;
		next_cycle_cnt = cycle_cnt;

		case (state)
			bus_idle:
			begin
				if (!DIN)
					next_state = wait_for_start;	// Member pulled the ring low
				next_cycle_cnt = CNT_W'(`ULPB_START_CYCLES - 1);
				next_reset_armed = 1'b0;
			end
			wait_for_start:
			begin
				if (cycle_cnt != '0)
					next_cycle_cnt = cycle_cnt - 1'b1;
				else
				begin
					next_state = enable_clk;
					next_clk_en = 1'b1;
				end
			end
			enable_clk:
				next_state = arbi_res;
			arbi_res:
			begin
				next_state = drive1;
				next_ctrl_hold = 1'b0;	// Open the ring
			end
			drive1:
			begin
				next_state = latch1;
				next_in_buf = {in_buf[0], DIN};
			end
			latch1:
				next_state = drive2;
			drive2:
			begin
				next_state = latch2;
				next_in_buf = {in_buf[0], DIN};
			end
			latch2:
			begin
				if (reset_armed)
				begin
					next_state = bus_reset;
					next_ctrl_hold = 1'b1;
				end
				else
				begin
					next_state = drive1;
					if (sample_diff)
						next_reset_armed = 1'b1;
				end
				next_cycle_cnt = CNT_W'(`ULPB_RESET_CYCLES - 1);
			end
			bus_reset:
			begin
				if (cycle_cnt != '0)
					next_cycle_cnt = cycle_cnt - 1'b1;
				else
				begin
					next_state = bus_disable;
					next_clk_en = 1'b0;	// Last ring clock edge
					next_cycle_cnt = CNT_W'(`ULPB_RESET_CYCLES - 1);
				end
			end
			bus_disable:
			begin
				if (cycle_cnt != '0)
					next_cycle_cnt = cycle_cnt - 1'b1;
				else
					next_state = bus_idle;
			end
			default:
				next_state = bus_idle;
		endcase
	end

endmodule

/* common/ulpb_pkg.sv */
`include "ulpb_config.svh"

package ulpb_pkg;

	typedef logic [`ULPB_ADDR_W-1:0] addr_t;
	typedef logic [`ULPB_DATA_W-1:0] data_t;

	typedef enum logic [3:0]
	{
		bus_idle,
		wait_for_start,
		enable_clk,
		arbi_res,
		drive1,
		latch1,
		drive2,
		latch2,
		bus_reset,
		bus_disable
	} med_state_t;

	typedef enum logic [1:0] {node_idle, node_frame, node_trailer} node_state_t;

	typedef logic [1:0] phase_t;	// Edge position within a round

endpackage

/* common/ulpb_config.svh */
`ifndef ULPB_CONFIG_SVH
`define ULPB_CONFIG_SVH

// Idle to ring clock delay after a request
`define ULPB_START_CYCLES 6

// Clock edges run while the line is held at frame end
`define ULPB_RESET_CYCLES 4

// Frame fields
`define ULPB_ADDR_W 4
`define ULPB_DATA_W 8

// Own address of the receiving member
`define ULPB_RX_ADDR 4'h5

`endif
